// File: include/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// core and cache port widths
`define LSU_DATA_W    32
`define L15_DATA_W    64
`define L15_RQTYPE_W  4
`define L15_SIZE_W    3

// request types toward the L1.5
`define RQ_LOAD       4'd0
`define RQ_STORE      4'd1

// return types from the L1.5
`define RET_LOAD      4'd0
`define RET_ST_ACK    4'd4

// request size codes
`define SIZE_0B       3'd0
`define SIZE_1B       3'd1
`define SIZE_2B       3'd2
`define SIZE_4B       3'd3

`endif

// File: source/lsu_pkg.sv
package lsu_pkg;

    // memory operation code, split into its fields
    //   width: 11 word, 01 half, 10 byte
    typedef struct packed {
        logic       is_store;  // 1 store, 0 load
        logic [1:0] width;
        logic       is_signed; // loads only
    } mem_op_fields_t;

    // legal codes
    //   0000 none
    //   1111 sw, 1011 sh, 1101 sb
    //   0111 lw, 0011 lh, 0010 lhu, 0101 lb, 0100 lbu
    typedef union packed {
        logic [3:0]     raw;
        mem_op_fields_t f;
    } mem_op_u;

endpackage

// File: source/op_capture.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module op_capture (
    input  logic                   clk,
    input  logic                   nrst,
    input  lsu_pkg::mem_op_u       mem_op,
    input  logic [`LSU_DATA_W-1:0] op_a,
    input  logic [`LSU_DATA_W-1:0] op_b,
    input  logic [`LSU_DATA_W-1:0] s_imm,
    input  logic                   stall_mem,
    input  logic                   dmem_finished,
    output lsu_pkg::mem_op_u       cap_op,
    output logic [`LSU_DATA_W-1:0] cap_a,
    output logic [`LSU_DATA_W-1:0] cap_b,
    output logic [`LSU_DATA_W-1:0] cap_imm
);

    logic stall_flag; // set once a stall has been seen
    logic hold;

    // first stall cycle still loads, later ones keep the value
    assign hold = stall_mem & stall_flag & ~dmem_finished;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            stall_flag <= 1'b0;
            cap_op     <= '0;
        end else begin
            if (dmem_finished)
                stall_flag <= 1'b0; // finish wins over a new stall
            else if (stall_mem)
                stall_flag <= 1'b1;
            if (!hold)
                cap_op <= mem_op;
        end
    end

    // operands
    always_ff @(posedge clk) begin
        if (!hold) begin
            cap_a   <= op_a;
            cap_b   <= op_b;
            cap_imm <= s_imm;
        end
    end

endmodule

// File: source/mem_decode.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module mem_decode (
    input  logic                   clk,
    input  logic                   nrst,
    input  lsu_pkg::mem_op_u       cap_op,
    input  logic [`LSU_DATA_W-1:0] cap_a,
    input  logic [`LSU_DATA_W-1:0] cap_b,
    input  logic [`LSU_DATA_W-1:0] cap_imm,
    output logic [`LSU_DATA_W-1:0] addr,
    output logic [`LSU_DATA_W-1:0] wdata,
    output logic                   rd,
    output logic [3:0]             byte_en,
    output lsu_pkg::mem_op_u       op,
    output logic                   m_op,
    output logic                   ld_addr_misaligned,
    output logic                   samo_addr_misaligned
);

    logic [`LSU_DATA_W-1:0] ea;       // effective address
    logic [`LSU_DATA_W-1:0] st_data;
    logic                   any_op;
    logic                   mis;
    logic                   ld_mis;
    logic                   st_mis;
    logic                   ld_rd;
    logic [3:0]             be;

    assign any_op = |cap_op.raw;

    // stores use the s-type offset, loads the i-type offset in op_b
    assign ea = cap_op.f.is_store ? (cap_a + cap_imm) : (cap_a + cap_b);

    // half and word need bit 0 clear, word needs bit 1 clear too
    assign mis = (cap_op.f.width[0] & ea[0])
               | (&cap_op.f.width & ea[1]);

    assign ld_mis = mis & ~cap_op.f.is_store;
    assign st_mis = mis & cap_op.f.is_store;
    assign ld_rd  = any_op & ~cap_op.f.is_store & ~mis;

    // byte enables, stores only
    always_comb begin
        be = 4'b0000;
        if (cap_op.f.is_store && !mis) begin
            case (cap_op.f.width)
                2'b11:   be = 4'b1111;
                2'b01:   be = ea[1] ? 4'b1100 : 4'b0011;
                2'b10:   be = 4'b0001 << ea[1:0];
                default: be = 4'b0000;
            endcase
        end
    end

    // replicate the store value across the lanes
    always_comb begin
        case (cap_op.f.width)
            2'b01:   st_data = {2{cap_b[15:0]}};
            2'b10:   st_data = {4{cap_b[7:0]}};
            default: st_data = cap_b; // word
        endcase
    end

    // stage 6, control
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            rd                   <= 1'b0;
            byte_en              <= 4'b0000;
            op                   <= '0;
            m_op                 <= 1'b0;
            ld_addr_misaligned   <= 1'b0;
            samo_addr_misaligned <= 1'b0;
        end else begin
            rd                   <= ld_rd;
            byte_en              <= be;
            op                   <= cap_op;
            m_op                 <= any_op;
            ld_addr_misaligned   <= ld_mis;
            samo_addr_misaligned <= st_mis;
        end
    end

    // stage 6, payload
    always_ff @(posedge clk) begin
        addr  <= ea;
        wdata <= st_data;
    end

endmodule

// File: source/l15_req_fsm.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module l15_req_fsm (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic [`LSU_DATA_W-1:0]  addr,
    input  logic [`LSU_DATA_W-1:0]  wdata,
    input  logic                    rd,
    input  logic [3:0]              byte_en,
    input  lsu_pkg::mem_op_u        op,
    input  logic                    l15_header_ack,
    input  logic                    l15_val,
    input  logic [`L15_RQTYPE_W-1:0] l15_returntype,
    output logic [`L15_RQTYPE_W-1:0] l15_rqtype,
    output logic [`L15_SIZE_W-1:0]  l15_size,
    output logic [`LSU_DATA_W-1:0]  l15_address,
    output logic [`L15_DATA_W-1:0]  l15_data,
    output logic                    l15_req_val,
    output logic                    l15_req_ack,
    output logic                    memop_done,
    output logic                    load_sel,
    output logic [`LSU_DATA_W-1:0]  ctx_addr,
    output lsu_pkg::mem_op_u        ctx_op
);

    logic                     in_resp;    // 0 request state, 1 response state
    logic [`L15_RQTYPE_W-1:0] req_type;
    logic [`L15_RQTYPE_W-1:0] ctx_rqtype;
    logic [`LSU_DATA_W-1:0]   wdata_sw;
    logic                     req_fire;
    logic                     ret_match;

    // cache side is big endian
    assign wdata_sw = {wdata[7:0], wdata[15:8], wdata[23:16], wdata[31:24]};

    assign req_type = (|byte_en) ? `RQ_STORE : `RQ_LOAD;

    always_comb begin
        if (|byte_en) begin
            case (byte_en)
                4'b1111:                            l15_size = `SIZE_4B;
                4'b0011, 4'b1100:                   l15_size = `SIZE_2B;
                4'b0001, 4'b0010, 4'b0100, 4'b1000: l15_size = `SIZE_1B;
                default:                            l15_size = `SIZE_0B;
            endcase
        end else if (rd) begin
            l15_size = `SIZE_4B; // loads always fetch a word
        end else begin
            l15_size = `SIZE_0B;
        end
    end

    assign l15_req_val = ~in_resp & ((|byte_en) | rd);
    assign l15_data    = {wdata_sw, wdata_sw};

    // show the latched request while waiting
    assign l15_rqtype  = in_resp ? ctx_rqtype : req_type;
    assign l15_address = in_resp ? ctx_addr : addr;

    assign req_fire  = l15_req_val & l15_header_ack;
    assign ret_match = ((ctx_rqtype == `RQ_LOAD) && (l15_returntype == `RET_LOAD))
                     | ((ctx_rqtype == `RQ_STORE) && (l15_returntype == `RET_ST_ACK));

    assign l15_req_ack = l15_val;
    assign memop_done  = in_resp & l15_val;
    assign load_sel    = in_resp & l15_val & (ctx_rqtype == `RQ_LOAD)
                       & (l15_returntype == `RET_LOAD);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            in_resp    <= 1'b0;
            ctx_rqtype <= `RQ_LOAD;
        end else if (!in_resp) begin
            if (req_fire) begin
                in_resp    <= 1'b1;
                ctx_rqtype <= req_type;
            end
        end else if (l15_val && ret_match) begin
            in_resp <= 1'b0; // other return types are dropped
        end
    end

    // request context for the load path
    always_ff @(posedge clk) begin
        if (req_fire) begin
            ctx_addr <= addr;
            ctx_op   <= op;
        end
    end

endmodule

// File: source/load_align.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module load_align (
    input  logic                   load_sel,
    input  logic [`LSU_DATA_W-1:0] ctx_addr,
    input  lsu_pkg::mem_op_u       ctx_op,
    input  logic [`L15_DATA_W-1:0] l15_data_0,
    input  logic [`L15_DATA_W-1:0] l15_data_1,
    output logic [`LSU_DATA_W-1:0] mem_out
);

    logic [`LSU_DATA_W-1:0] rword;
    logic [`LSU_DATA_W-1:0] rword_sw;
    logic [7:0]             rbyte;
    logic [15:0]            rhalf;

    // addr[3:2] picks one of four words in the 16-byte response
    always_comb begin
        case (ctx_addr[3:2])
            2'b00:   rword = l15_data_0[63:32];
            2'b01:   rword = l15_data_0[31:0];
            2'b10:   rword = l15_data_1[63:32];
            default: rword = l15_data_1[31:0];
        endcase
    end

    assign rword_sw = {rword[7:0], rword[15:8], rword[23:16], rword[31:24]};

    assign rbyte = rword_sw[8*ctx_addr[1:0] +: 8];
    assign rhalf = rword_sw[16*ctx_addr[1] +: 16]; // aligned halves only

    always_comb begin
        if (!load_sel) begin
            mem_out = '0;
        end else begin
            case (ctx_op.f.width)
                2'b11:   mem_out = rword_sw;
                2'b01:   mem_out = {{16{ctx_op.f.is_signed & rhalf[15]}}, rhalf};
                2'b10:   mem_out = {{24{ctx_op.f.is_signed & rbyte[7]}}, rbyte};
                default: mem_out = '0;
            endcase
        end
    end

endmodule

// File: source/mem_wrap.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module mem_wrap (
    input  logic                     clk,
    input  logic                     nrst,
    input  lsu_pkg::mem_op_u         mem_op,
    input  logic [`LSU_DATA_W-1:0]   op_a,    // base address
    input  logic [`LSU_DATA_W-1:0]   op_b,    // store value or load offset
    input  logic [`LSU_DATA_W-1:0]   s_imm,   // store offset
    input  logic                     stall_mem,
    input  logic                     dmem_finished,
    // L1.5 request
    output logic [`L15_RQTYPE_W-1:0] l15_rqtype,
    output logic [`L15_SIZE_W-1:0]   l15_size,
    output logic [`LSU_DATA_W-1:0]   l15_address,
    output logic [`L15_DATA_W-1:0]   l15_data,
    output logic                     l15_req_val,
    input  logic                     l15_header_ack,
    // L1.5 response
    input  logic                     l15_val,
    input  logic [`L15_RQTYPE_W-1:0] l15_returntype,
    input  logic [`L15_DATA_W-1:0]   l15_data_0,
    input  logic [`L15_DATA_W-1:0]   l15_data_1,
    output logic                     l15_req_ack,
    // back to the core
    output logic [`LSU_DATA_W-1:0]   mem_out,
    output logic                     memop_done,
    output logic                     m_op,
    output logic                     ld_addr_misaligned,
    output logic                     samo_addr_misaligned
);

    lsu_pkg::mem_op_u       cap_op;
    logic [`LSU_DATA_W-1:0] cap_a;
    logic [`LSU_DATA_W-1:0] cap_b;
    logic [`LSU_DATA_W-1:0] cap_imm;

    logic [`LSU_DATA_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
    logic                   rd;
    logic [3:0]             byte_en;
    lsu_pkg::mem_op_u       op;

    logic                   load_sel;
    logic [`LSU_DATA_W-1:0] ctx_addr;
    lsu_pkg::mem_op_u       ctx_op;

    op_capture u_op_capture (
        .clk           (clk),
        .nrst          (nrst),
        .mem_op        (mem_op),
        .op_a          (op_a),
        .op_b          (op_b),
        .s_imm         (s_imm),
        .stall_mem     (stall_mem),
        .dmem_finished (dmem_finished),
        .cap_op        (cap_op),
        .cap_a         (cap_a),
        .cap_b         (cap_b),
        .cap_imm       (cap_imm)
    );

    mem_decode u_mem_decode (
        .clk                  (clk),
        .nrst                 (nrst),
        .cap_op               (cap_op),
        .cap_a                (cap_a),
        .cap_b                (cap_b),
        .cap_imm              (cap_imm),
        .addr                 (addr),
        .wdata                (wdata),
        .rd                   (rd),
        .byte_en              (byte_en),
        .op                   (op),
        .m_op                 (m_op),
        .ld_addr_misaligned   (ld_addr_misaligned),
        .samo_addr_misaligned (samo_addr_misaligned)
    );

    l15_req_fsm u_l15_req_fsm (
        .clk            (clk),
        .nrst           (nrst),
        .addr           (addr),
        .wdata          (wdata),
        .rd             (rd),
        .byte_en        (byte_en),
        .op             (op),
        .l15_header_ack (l15_header_ack),
        .l15_val        (l15_val),
        .l15_returntype (l15_returntype),
        .l15_rqtype     (l15_rqtype),
        .l15_size       (l15_size),
        .l15_address    (l15_address),
        .l15_data       (l15_data),
        .l15_req_val    (l15_req_val),
        .l15_req_ack    (l15_req_ack),
        .memop_done     (memop_done),
        .load_sel       (load_sel),
        .ctx_addr       (ctx_addr),
        .ctx_op         (ctx_op)
    );

    load_align u_load_align (
        .load_sel   (load_sel),
        .ctx_addr   (ctx_addr),
        .ctx_op     (ctx_op),
        .l15_data_0 (l15_data_0),
        .l15_data_1 (l15_data_1),
        .mem_out    (mem_out)
    );

endmodule

// File: tb/mem_wrap_assert.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module mem_wrap_assert (
    input logic                     clk,
    input logic                     nrst,
    input logic [`L15_RQTYPE_W-1:0] l15_rqtype,
    input logic                     l15_req_val,
    input logic                     l15_header_ack,
    input logic                     l15_val,
    input logic [`L15_RQTYPE_W-1:0] l15_returntype,
    input logic                     memop_done,
    input logic                     ld_addr_misaligned,
    input logic                     samo_addr_misaligned
);

    logic                     waiting;   // fired, no matching return yet
    logic [`L15_RQTYPE_W-1:0] wait_type;
    logic                     answered;
    int                       fail_count = 0;

    assign answered = l15_val
        & (((wait_type == `RQ_LOAD) & (l15_returntype == `RET_LOAD))
        | ((wait_type == `RQ_STORE) & (l15_returntype == `RET_ST_ACK)));

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            waiting   <= 1'b0;
            wait_type <= `RQ_LOAD;
        end else if (!waiting) begin
            if (l15_req_val && l15_header_ack) begin
                waiting   <= 1'b1;
                wait_type <= l15_rqtype;
            end
        end else if (answered) begin
            waiting <= 1'b0;
        end
    end

    a_val_aligned: assert property (@(posedge clk) disable iff (!nrst)
        l15_req_val |-> !(ld_addr_misaligned || samo_addr_misaligned))
        else begin
            $error("request valid raised for a misaligned access");
            fail_count = fail_count + 1;
        end

    a_val_idle_wait: assert property (@(posedge clk) disable iff (!nrst)
        l15_req_val |-> !waiting)
        else begin
            $error("request valid raised while a response is pending");
            fail_count = fail_count + 1;
        end

    a_done_after_fire: assert property (@(posedge clk) disable iff (!nrst)
        memop_done |-> waiting)
        else begin
            $error("memop_done raised with no request outstanding");
            fail_count = fail_count + 1;
        end

endmodule

bind mem_wrap mem_wrap_assert i_mem_wrap_assert (
    .clk                  (clk),
    .nrst                 (nrst),
    .l15_rqtype           (l15_rqtype),
    .l15_req_val          (l15_req_val),
    .l15_header_ack       (l15_header_ack),
    .l15_val              (l15_val),
    .l15_returntype       (l15_returntype),
    .memop_done           (memop_done),
    .ld_addr_misaligned   (ld_addr_misaligned),
    .samo_addr_misaligned (samo_addr_misaligned)
);

// File: tb/tb_mem_wrap.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_mem_wrap;

    localparam logic [3:0] OP_NONE = 4'b0000;
    localparam logic [3:0] OP_SW   = 4'b1111;
    localparam logic [3:0] OP_SH   = 4'b1011;
    localparam logic [3:0] OP_SB   = 4'b1101;
    localparam logic [3:0] OP_LW   = 4'b0111;
    localparam logic [3:0] OP_LH   = 4'b0011;
    localparam logic [3:0] OP_LHU  = 4'b0010;
    localparam logic [3:0] OP_LB   = 4'b0101;
    localparam logic [3:0] OP_LBU  = 4'b0100;

    // 6 stores, 52 loads, 4 misaligned, 2 wrong type, 1 stall
    localparam int N_OPS      = 65;
    localparam int MAX_CYCLES = 40 * N_OPS + 100;

    logic                     clk = 1'b0;
    logic                     nrst;
    lsu_pkg::mem_op_u         mem_op;
    logic [`LSU_DATA_W-1:0]   op_a, op_b, s_imm;
    logic                     stall_mem, dmem_finished;
    logic [`L15_RQTYPE_W-1:0] l15_rqtype, l15_returntype;
    logic [`L15_SIZE_W-1:0]   l15_size;
    logic [`LSU_DATA_W-1:0]   l15_address, mem_out;
    logic [`L15_DATA_W-1:0]   l15_data, l15_data_0, l15_data_1;
    logic                     l15_req_val, l15_header_ack, l15_val, l15_req_ack;
    logic                     memop_done, m_op, ld_addr_misaligned, samo_addr_misaligned;

    logic [31:0] seed = 32'h9bac_6877;
    int          cycles = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          test_errors = 0;

    mem_wrap i_mem_wrap (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [2:0] exp_size(input logic [3:0] code);
        case (code)
            OP_SH:   return `SIZE_2B;
            OP_SB:   return `SIZE_1B;
            default: return `SIZE_4B; // sw and every load
        endcase
    endfunction

    // lowest address byte goes out first, in both halves
    function automatic logic [63:0] exp_store_data(input logic [3:0] code, input logic [31:0] v);
        logic [31:0] w;
        case (code)
            OP_SH:   w = {2{v[15:0]}};
            OP_SB:   w = {4{v[7:0]}};
            default: w = v;
        endcase
        return {2{w[7:0], w[15:8], w[23:16], w[31:24]}};
    endfunction

    function automatic logic [31:0] exp_load(input logic [3:0] code, input logic [31:0] ea,
                                             input logic [63:0] d0, input logic [63:0] d1);
        logic [31:0] w;
        logic [7:0]  b [4];
        logic [15:0] h;
        int          o;
        int          k;
        case (ea[3:2])
            2'd0:    w = d0[63:32];
            2'd1:    w = d0[31:0];
            2'd2:    w = d1[63:32];
            default: w = d1[31:0];
        endcase
        for (k = 0; k < 4; k++)
            b[k] = w[31-8*k -: 8]; // big endian, byte k sits at offset k
        o = int'(ea[1:0]);
        h = {b[o|1], b[o]};
        case (code)
            OP_LW:   return {b[3], b[2], b[1], b[0]};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            OP_LB:   return {{24{b[o][7]}}, b[o]};
            OP_LBU:  return {24'h0, b[o]};
            default: return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        assert (exp === act) else begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic start_op(input logic [3:0] code, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] imm);
        mem_op.raw = code;
        op_a       = a;
        op_b       = b;
        s_imm      = imm;
    endtask

    // leave the op off until stage 6 is empty again
    task automatic withdraw();
        mem_op.raw = OP_NONE;
        repeat (2) @(negedge clk);
    endtask

    task automatic wait_request(input string name, output bit seen);
        int n;
        n = 0;
        #1;
        while (!l15_req_val && n < 6) begin
            @(negedge clk);
            #1;
            n++;
        end
        seen = l15_req_val;
        n_checks++;
        assert (seen) else begin
            $display("%s: the request valid did not come within %0d cycles", name, n);
            n_errors++;
            test_errors++;
        end
    endtask

    // one full access with a single header ack and a random response delay
    task automatic access(input string name, input logic [3:0] code, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] imm);
        logic [31:0] ea;
        logic [63:0] d0;
        logic [63:0] d1;
        bit          seen;
        int          delay;
        ea    = code[3] ? a + imm : a + b;
        d0    = {rand32(), rand32()};
        d1    = {rand32(), rand32()};
        delay = int'(rand32() >> 30) + 1;
        @(negedge clk);
        start_op(code, a, b, imm);
        wait_request(name, seen);
        if (seen) begin
            check_value({name, " m_op"}, 1, m_op);
            check_value({name, " rqtype"}, code[3] ? `RQ_STORE : `RQ_LOAD, l15_rqtype);
            check_value({name, " size"}, exp_size(code), l15_size);
            check_value({name, " address"}, ea, l15_address);
            if (code[3])
                check_value({name, " data"}, exp_store_data(code, b), l15_data);
            @(negedge clk);
            l15_header_ack = 1'b1;
            @(negedge clk);
            l15_header_ack = 1'b0;
            repeat (delay - 1) @(negedge clk);
            l15_val        = 1'b1;
            l15_returntype = code[3] ? `RET_ST_ACK : `RET_LOAD;
            l15_data_0     = d0;
            l15_data_1     = d1;
            #1;
            check_value({name, " done"}, 1, memop_done);
            check_value({name, " req_ack"}, 1, l15_req_ack);
            if (!code[3])
                check_value({name, " mem_out"}, exp_load(code, ea, d0, d1), mem_out);
            @(negedge clk);
            l15_val = 1'b0;
        end
        withdraw();
    endtask

    task automatic misaligned(input string name, input logic [3:0] code,
                              input logic [31:0] a, input logic [31:0] off);
        @(negedge clk);
        start_op(code, a, off, off);
        repeat (4) begin
            #1;
            check_value({name, " val"}, 0, l15_req_val);
            @(negedge clk);
        end
        #1;
        check_value({name, " load flag"}, !code[3], ld_addr_misaligned);
        check_value({name, " store flag"}, code[3], samo_addr_misaligned);
        withdraw();
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] a2;
        int          off;
        int          total;
        bit          seen;
        nrst           = 1'b0;
        mem_op         = '0;
        op_a           = '0;
        op_b           = '0;
        s_imm          = '0;
        stall_mem      = 1'b0;
        dmem_finished  = 1'b0;
        l15_header_ack = 1'b0;
        l15_val        = 1'b0;
        l15_returntype = '0;
        l15_data_0     = '0;
        l15_data_1     = '0;
        repeat (4) @(negedge clk);
        nrst = 1'b1;
        #1;
        check_value("reset val", 0, l15_req_val);
        check_value("reset done", 0, memop_done);
        check_value("reset m_op", 0, m_op);
        check_value("reset ld mis", 0, ld_addr_misaligned);
        check_value("reset st mis", 0, samo_addr_misaligned);
        end_test("reset");

        // offsets picked so the sum lands aligned
        repeat (2) begin
            a = rand32();
            access("sw", OP_SW, a, rand32(), (rand32() & ~32'h3) - a);
            access("sh", OP_SH, a, rand32(), (rand32() & ~32'h1) - a);
            access("sb", OP_SB, a, rand32(), rand32() - a);
        end
        end_test("store");

        for (off = 0; off < 16; off++) begin
            a = rand32() & ~32'hf; // offset covers the whole 16-byte response
            if (off % 4 == 0)
                access("lw", OP_LW, a, 32'(off), rand32());
            if (off % 2 == 0) begin
                access("lh", OP_LH, a, 32'(off), rand32());
                access("lhu", OP_LHU, a, 32'(off), rand32());
            end
            access("lb", OP_LB, a, 32'(off), rand32());
            access("lbu", OP_LBU, a, 32'(off), rand32());
        end
        end_test("load");

        a = rand32() & ~32'h3;
        misaligned("lh", OP_LH, a, 32'd1);
        misaligned("lw", OP_LW, a, 32'd2);
        misaligned("sh", OP_SH, a, 32'd3);
        misaligned("sw", OP_SW, a, 32'd1);
        end_test("misaligned");

        // a load return while a store waits
        @(negedge clk);
        start_op(OP_SW, a, rand32(), 32'd0);
        wait_request("wrong type", seen);
        @(negedge clk);
        l15_header_ack = 1'b1;
        @(negedge clk);
        l15_header_ack = 1'b0;
        l15_val        = 1'b1;
        l15_returntype = `RET_LOAD;
        @(negedge clk);
        l15_val = 1'b0;
        #1;
        check_value("wrong type still waits", 0, l15_req_val);
        @(negedge clk);
        l15_val        = 1'b1;
        l15_returntype = `RET_ST_ACK;
        #1;
        check_value("st ack done", 1, memop_done);
        @(negedge clk);
        l15_val = 1'b0;
        #1;
        check_value("back to request", 1, l15_req_val);
        @(negedge clk);
        l15_val = 1'b1; // stray response, nothing outstanding
        #1;
        check_value("stray response done", 0, memop_done);
        @(negedge clk);
        l15_val = 1'b0;
        withdraw();
        access("sb after ack", OP_SB, a, rand32(), 32'd0);
        end_test("wrong type");

        a  = rand32() & ~32'h3;
        a2 = a + 32'h100;
        @(negedge clk);
        start_op(OP_LW, a, 32'd0, 32'd0);
        stall_mem = 1'b1; // first stall cycle still loads
        @(negedge clk);
        op_a = a2;
        @(negedge clk);
        #1;
        check_value("stall addr 1", a, l15_address);
        @(negedge clk);
        #1;
        check_value("stall addr 2", a, l15_address);
        @(negedge clk);
        dmem_finished = 1'b1;
        #1;
        check_value("stall addr 3", a, l15_address);
        @(negedge clk);
        dmem_finished = 1'b0;
        stall_mem     = 1'b0;
        @(negedge clk);
        #1;
        check_value("released addr", a2, l15_address);
        withdraw();
        end_test("stall");

        total = n_errors + i_mem_wrap.i_mem_wrap_assert.fail_count;
        $display("%0d checks, %0d check errors, %0d assertion failures",
                 n_checks, n_errors, i_mem_wrap.i_mem_wrap_assert.fail_count);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
source/lsu_pkg.sv
source/op_capture.sv
source/mem_decode.sv
source/l15_req_fsm.sv
source/load_align.sv
source/mem_wrap.sv
tb/mem_wrap_assert.sv
tb/tb_mem_wrap.sv

// File: Makefile
TOOL       := verilator
TOP        := tb_mem_wrap
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := === PASS ===
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
RUN_ARGS   := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
